// File: fft_wb_top.f
verilog/fft_pkg.sv
verilog/fft_core_if.sv
verilog/fft_butterfly.sv
verilog/fft_stage.sv
verilog/fft_core.sv
verilog/fft_wb_regs.sv
verilog/fft_wb_top.sv
test/tb_fft_wb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_fft_wb \
    -f fft_wb_top.f -o tb_fft_wb \
    && ./obj_dir/tb_fft_wb | tee /dev/stderr | grep -q "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/fft_testdata.hex
// input sample n then expected real and imaginary bin n, all Q16.16.
// first 32 rows are frame 1, the next 32 rows frame 2.
00018000 00110000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00008000 00010000 00000000
00024000 00250000 00000000
FFFE8000 00000000 00000000
0000C000 00000000 00000000
00032000 00000000 00000000
00024000 00000000 00000000
FFFE8000 00000000 00000000
0000C000 00000000 00000000
00032000 00000000 00000000
00024000 000C0000 00250000
FFFE8000 00000000 00000000
0000C000 00000000 00000000
00032000 00000000 00000000
00024000 00000000 00000000
FFFE8000 00000000 00000000
0000C000 00000000 00000000
00032000 00000000 00000000
00024000 000B0000 00000000
FFFE8000 00000000 00000000
0000C000 00000000 00000000
00032000 00000000 00000000
00024000 00000000 00000000
FFFE8000 00000000 00000000
0000C000 00000000 00000000
00032000 00000000 00000000
00024000 000C0000 FFDB0000
FFFE8000 00000000 00000000
0000C000 00000000 00000000
00032000 00000000 00000000
00024000 00000000 00000000
FFFE8000 00000000 00000000
0000C000 00000000 00000000
00032000 00000000 00000000

// File: test/tb_fft_wb.sv
module tb_fft_wb;
    timeunit 1ns;
    timeprecision 1ps;

    import fft_pkg::*;

    localparam int NPTS         = 32;
    localparam int ACK_TIMEOUT  = 16;
    localparam int DONE_TIMEOUT = 200;

    logic     clk;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    sample_t  wb_wdata;
    sample_t  wb_rdata;
    logic     wb_ack;

    // each row holds an input sample and the expected bin real and imag.
    logic [31:0] test_data [0:6*NPTS-1];
    integer      seed;
    int          order [NPTS];

    fft_wb_top #(
        .POINTS_LOG2 (5)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input sample_t got, input sample_t exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // one classic cycle with ack sampled at the falling edge.
    task automatic wb_cycle(input logic we, input wb_addr_t adr, input sample_t wdata,
                            output sample_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= wdata;
        @(negedge clk);
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (wb_ack) else begin
            $display("no wb_ack within %0d cycles for address %h at %0t ns",
                     ACK_TIMEOUT, adr, $time);
            stop_run();
        end
        assert (waited == 1) else begin
            $display("Error at %0t ns: wb_ack came after %0d cycles, expected 1", $time, waited);
            stop_run();
        end
        rdata = wb_rdata;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        // ack must drop right after its single cycle.
        @(negedge clk);
        assert (!wb_ack) else begin
            $display("wb_ack stayed high for a second cycle at %0t ns", $time);
            stop_run();
        end
    endtask

    task automatic write_word(input wb_addr_t adr, input sample_t data);
        sample_t unused;
        wb_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_word(input wb_addr_t adr, output sample_t data);
        wb_cycle(1'b0, adr, '0, data);
    endtask

    // poll until a frame finished and no stage holds another one.
    task automatic wait_done();
        sample_t status;
        int      polls;
        polls = 0;
        read_word(ADDR_STATUS, status);
        while (status[1:0] != 2'b10 && polls < DONE_TIMEOUT) begin
            read_word(ADDR_STATUS, status);
            polls++;
        end
        assert (status[1:0] == 2'b10) else begin
            $display("transform did not finish within %0d status polls", DONE_TIMEOUT);
            stop_run();
        end
    endtask

    task automatic check_bins(input int frame);
        sample_t got;
        int      row;
        for (int k = 0; k < NPTS; k++) begin
            row = 3 * (frame * NPTS + k);
            read_word(ADDR_RESULT_REAL_BASE + wb_addr_t'(k), got);
            check_value($sformatf("frame %0d bin %0d real", frame + 1, k), got,
                        test_data[row + 1]);
            read_word(ADDR_RESULT_IMAG_BASE + wb_addr_t'(k), got);
            check_value($sformatf("frame %0d bin %0d imag", frame + 1, k), got,
                        test_data[row + 2]);
        end
    endtask

    task automatic load_frame(input int frame, input bit shuffled);
        int j;
        int tmp;
        for (int n = 0; n < NPTS; n++) begin
            order[n] = n;
        end
        // shuffle the write order with the seeded generator.
        if (shuffled) begin
            for (int i = NPTS - 1; i > 0; i--) begin
                j = int'($unsigned($random(seed)) % (i + 1));
                tmp      = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
        end
        for (int n = 0; n < NPTS; n++) begin
            write_word(ADDR_SAMPLE_BASE + wb_addr_t'(order[n]),
                       test_data[3 * (frame * NPTS + order[n])]);
        end
    endtask

    initial begin
        sample_t rd;
        seed     = 32'h2cd7c6c5;
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;
        $readmemh("test/fft_testdata.hex", test_data);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // idle status and cleared result buffer.
        read_word(ADDR_STATUS, rd);
        check_value("status after reset", rd, '0);
        for (int k = 0; k < NPTS; k++) begin
            read_word(ADDR_RESULT_REAL_BASE + wb_addr_t'(k), rd);
            check_value($sformatf("bin %0d real after reset", k), rd, '0);
            read_word(ADDR_RESULT_IMAG_BASE + wb_addr_t'(k), rd);
            check_value($sformatf("bin %0d imag after reset", k), rd, '0);
        end

        // impulse plus constant written out of order.
        load_frame(0, 1'b1);
        write_word(ADDR_CTRL, 32'd1);
        wait_done();
        check_bins(0);

        // second frame has to replace the first result.
        load_frame(1, 1'b0);
        write_word(ADDR_CTRL, 32'd1);
        read_word(ADDR_STATUS, rd);
        check_value("status right after start", rd, 32'd1);
        wait_done();
        check_bins(1);

        // unmapped words read as zero and writes there still get an ack.
        read_word(7'h22, rd);
        check_value("unmapped address 22", rd, '0);
        write_word(7'h30, 32'hDEADBEEF);
        read_word(7'h3F, rd);
        check_value("unmapped address 3f", rd, '0);

        // two frames in flight at once.
        write_word(ADDR_CTRL, 32'd1);
        write_word(ADDR_CTRL, 32'd1);
        // the sample buffer changes while both frames are still in the stages.
        load_frame(0, 1'b0);
        wait_done();
        check_bins(1);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: verilog/fft_butterfly.sv
module fft_butterfly (
    input  fft_pkg::sample_t a_real,
    input  fft_pkg::sample_t a_imag,
    input  fft_pkg::sample_t b_real,
    input  fft_pkg::sample_t b_imag,
    input  fft_pkg::sample_t w_real,
    input  fft_pkg::sample_t w_imag,
    output fft_pkg::sample_t y0_real,
    output fft_pkg::sample_t y0_imag,
    output fft_pkg::sample_t y1_real,
    output fft_pkg::sample_t y1_imag
);
    import fft_pkg::*;

    // full width partial products.
    logic signed [63:0] prod_rr;
    logic signed [63:0] prod_ii;
    logic signed [63:0] prod_ri;
    logic signed [63:0] prod_ir;

    sample_t p_real;
    sample_t p_imag;

    // operands are sign extended to 64 bits by the assignment width.
    assign prod_rr = b_real * w_real;
    assign prod_ii = b_imag * w_imag;
    assign prod_ri = b_real * w_imag;
    assign prod_ir = b_imag * w_real;

    // back to Q16.16, each term truncated before combining.
    assign p_real = sample_t'(prod_rr >>> 16) - sample_t'(prod_ii >>> 16);
    assign p_imag = sample_t'(prod_ri >>> 16) + sample_t'(prod_ir >>> 16);

    // sum and difference wrap at 32 bits.
    assign y0_real = a_real + p_real;
    assign y0_imag = a_imag + p_imag;
    assign y1_real = a_real - p_real;
    assign y1_imag = a_imag - p_imag;

endmodule

// File: verilog/fft_core.sv
module fft_core #(
    parameter int POINTS_LOG2 = 5
) (
    input  logic       clk,
    input  logic       rst_n,
    fft_core_if.core   bus
);
    import fft_pkg::*;

    localparam int NPTS = 1 << POINTS_LOG2;

    // reverse the low POINTS_LOG2 bits of an index.
    function automatic int bit_rev(input int idx);
        int rev;
        rev = 0;
        for (int b = 0; b < POINTS_LOG2; b++) begin
            rev = rev | (((idx >> b) & 1) << (POINTS_LOG2 - 1 - b));
        end
        return rev;
    endfunction

    sample_t sample_buf  [NPTS];
    sample_t result_real [NPTS];
    sample_t result_imag [NPTS];

    // one level per stage boundary, level 0 feeds stage 0.
    sample_t lvl_real [POINTS_LOG2 + 1][NPTS];
    sample_t lvl_imag [POINTS_LOG2 + 1][NPTS];
    logic [POINTS_LOG2:0] lvl_valid;

    // natural order writes from the bus.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_buf <= '{default: '0};
        end else if (bus.sample_we) begin
            sample_buf[bus.sample_idx[POINTS_LOG2-1:0]] <= bus.sample_data;
        end
    end

    // bit reversed pairing is pure wiring, input is real only.
    for (genvar n = 0; n < NPTS; n++) begin : g_feed
        assign lvl_real[0][n] = sample_buf[bit_rev(n)];
        assign lvl_imag[0][n] = '0;
    end

    assign lvl_valid[0] = bus.start;

    for (genvar s = 0; s < POINTS_LOG2; s++) begin : g_stage
        fft_stage #(
            .POINTS_LOG2 (POINTS_LOG2),
            .STAGE       (s)
        ) u_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lvl_valid[s]),
            .in_real   (lvl_real[s]),
            .in_imag   (lvl_imag[s]),
            .out_valid (lvl_valid[s+1]),
            .out_real  (lvl_real[s+1]),
            .out_imag  (lvl_imag[s+1])
        );
    end

    // a later frame simply overwrites the previous result.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_real <= '{default: '0};
            result_imag <= '{default: '0};
        end else if (lvl_valid[POINTS_LOG2]) begin
            result_real <= lvl_real[POINTS_LOG2];
            result_imag <= lvl_imag[POINTS_LOG2];
        end
    end

    assign bus.result_real = result_real[bus.result_idx[POINTS_LOG2-1:0]];
    assign bus.result_imag = result_imag[bus.result_idx[POINTS_LOG2-1:0]];

    // any stage holding a frame.
    assign bus.busy = |lvl_valid[POINTS_LOG2:1];
    // high in the cycle whose closing edge loads the result buffer.
    assign bus.done = lvl_valid[POINTS_LOG2];

endmodule

// File: verilog/fft_core_if.sv
interface fft_core_if;
    import fft_pkg::*;

    // sample buffer write port.
    logic     sample_we;
    bin_idx_t sample_idx;
    sample_t  sample_data;

    // one-cycle start pulse.
    logic     start;

    // result buffer read port, combinational.
    bin_idx_t result_idx;
    sample_t  result_real;
    sample_t  result_imag;

    logic     busy;
    logic     done;

    modport host (
        output sample_we, sample_idx, sample_data, start, result_idx,
        input  result_real, result_imag, busy, done
    );

    modport core (
        input  sample_we, sample_idx, sample_data, start, result_idx,
        output result_real, result_imag, busy, done
    );

endinterface

// File: verilog/fft_pkg.sv
package fft_pkg;

    // largest transform the twiddle table covers, 32 points.
    localparam int MAX_POINTS_LOG2 = 5;

    // signed Q16.16 fixed point.
    typedef logic signed [31:0] sample_t;
    typedef logic [3:0] twiddle_idx_t;
    typedef logic [6:0] wb_addr_t;
    typedef logic [4:0] bin_idx_t;

    // word address map.
    localparam wb_addr_t ADDR_SAMPLE_BASE      = 7'h00;
    localparam wb_addr_t ADDR_CTRL             = 7'h20;
    localparam wb_addr_t ADDR_STATUS           = 7'h21;
    localparam wb_addr_t ADDR_RESULT_REAL_BASE = 7'h40;
    localparam wb_addr_t ADDR_RESULT_IMAG_BASE = 7'h60;

    // cos(2*pi*k/32) in Q16.16.
    localparam sample_t TW_REAL [16] = '{
        32'h00010000, 32'h0000FB15, 32'h0000EC83, 32'h0000D4DB,
        32'h0000B505, 32'h00008E3A, 32'h000061F8, 32'h000031F1,
        32'h00000000, 32'hFFFFCE0E, 32'hFFFF9E08, 32'hFFFF71C6,
        32'hFFFF4AFB, 32'hFFFF2B24, 32'hFFFF137C, 32'hFFFF04EB
    };

    // -sin(2*pi*k/32) in Q16.16.
    localparam sample_t TW_IMAG [16] = '{
        32'h00000000, 32'hFFFFCE0E, 32'hFFFF9E08, 32'hFFFF71C6,
        32'hFFFF4AFB, 32'hFFFF2B24, 32'hFFFF137C, 32'hFFFF04EB,
        32'hFFFF0000, 32'hFFFF04EB, 32'hFFFF137C, 32'hFFFF2B24,
        32'hFFFF4AFB, 32'hFFFF71C6, 32'hFFFF9E08, 32'hFFFFCE0E
    };

    // real part when imag is low, imaginary part otherwise.
    function automatic sample_t twiddle(input twiddle_idx_t idx, input logic imag);
        if (imag) begin
            return TW_IMAG[idx];
        end
        return TW_REAL[idx];
    endfunction

endpackage

// File: verilog/fft_stage.sv
module fft_stage #(
    parameter int POINTS_LOG2 = 5,
    parameter int STAGE       = 0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  fft_pkg::sample_t in_real  [1 << POINTS_LOG2],
    input  fft_pkg::sample_t in_imag  [1 << POINTS_LOG2],
    output logic             out_valid,
    output fft_pkg::sample_t out_real [1 << POINTS_LOG2],
    output fft_pkg::sample_t out_imag [1 << POINTS_LOG2]
);
    import fft_pkg::*;

    localparam int NPTS = 1 << POINTS_LOG2;
    localparam int SPAN = 1 << STAGE;
    // twiddle step for this stage, in 32-point table units.
    localparam int TW_STEP = 1 << (MAX_POINTS_LOG2 - 1 - STAGE);

    sample_t bf_real [NPTS];
    sample_t bf_imag [NPTS];

    for (genvar b = 0; b < NPTS / 2; b++) begin : g_bfly
        localparam int GRP = b / SPAN;
        localparam int J   = b % SPAN;
        localparam int TOP = GRP * 2 * SPAN + J;
        localparam int BOT = TOP + SPAN;
        localparam twiddle_idx_t TW = twiddle_idx_t'(J * TW_STEP);

        fft_butterfly u_bfly (
            .a_real  (in_real[TOP]),
            .a_imag  (in_imag[TOP]),
            .b_real  (in_real[BOT]),
            .b_imag  (in_imag[BOT]),
            .w_real  (twiddle(TW, 1'b0)),
            .w_imag  (twiddle(TW, 1'b1)),
            .y0_real (bf_real[TOP]),
            .y0_imag (bf_imag[TOP]),
            .y1_real (bf_real[BOT]),
            .y1_imag (bf_imag[BOT])
        );
    end

    // frame tag follows the data through the stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // data register loads every cycle, valid tells the frame apart.
    always_ff @(posedge clk) begin
        out_real <= bf_real;
        out_imag <= bf_imag;
    end

endmodule

// File: verilog/fft_wb_regs.sv
module fft_wb_regs #(
    parameter int POINTS_LOG2 = 5
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  fft_pkg::wb_addr_t  wb_adr,
    input  fft_pkg::sample_t   wb_wdata,
    output fft_pkg::sample_t   wb_rdata,
    output logic               wb_ack,
    fft_core_if.host           core
);
    import fft_pkg::*;

    localparam int NPTS = 1 << POINTS_LOG2;

    logic     req;
    bin_idx_t offset;
    logic     in_range;
    logic     sample_hit;
    logic     real_hit;
    logic     imag_hit;
    logic     ctrl_hit;
    logic     status_hit;
    logic     done_flag;
    sample_t  rd_value;

    // new request only, the ack cycle itself is not a request.
    assign req = wb_cyc && wb_stb && !wb_ack;

    // low five bits index samples and bins.
    assign offset   = bin_idx_t'(wb_adr);
    assign in_range = 32'(offset) < NPTS;

    assign sample_hit = (wb_adr[6:5] == ADDR_SAMPLE_BASE[6:5]) && in_range;
    assign real_hit   = (wb_adr[6:5] == ADDR_RESULT_REAL_BASE[6:5]) && in_range;
    assign imag_hit   = (wb_adr[6:5] == ADDR_RESULT_IMAG_BASE[6:5]) && in_range;
    assign ctrl_hit   = wb_adr == ADDR_CTRL;
    assign status_hit = wb_adr == ADDR_STATUS;

    // sample writes go straight to the buffer at the request edge.
    assign core.sample_we   = req && wb_we && sample_hit;
    assign core.sample_idx  = offset;
    assign core.sample_data = wb_wdata;
    assign core.result_idx  = offset;

    // unmapped and write-only words read as zero.
    always_comb begin
        rd_value = '0;
        if (status_hit) begin
            rd_value = sample_t'({done_flag, core.busy});
        end else if (real_hit) begin
            rd_value = core.result_real;
        end else if (imag_hit) begin
            rd_value = core.result_imag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            wb_rdata   <= '0;
            core.start <= 1'b0;
        end else begin
            wb_ack     <= req;
            core.start <= req && wb_we && ctrl_hit && wb_wdata[0];
            if (req && !wb_we) begin
                wb_rdata <= rd_value;
            end else begin
                wb_rdata <= '0;
            end
        end
    end

    // done since the last start, a new start wins over a late done.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_flag <= 1'b0;
        end else if (core.start) begin
            done_flag <= 1'b0;
        end else if (core.done) begin
            done_flag <= 1'b1;
        end
    end

endmodule

// File: verilog/fft_wb_top.sv
module fft_wb_top #(
    parameter int POINTS_LOG2 = 5
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  fft_pkg::wb_addr_t wb_adr,
    input  fft_pkg::sample_t  wb_wdata,
    output fft_pkg::sample_t  wb_rdata,
    output logic              wb_ack
);

    fft_core_if core_bus ();

    // bus slave and register decode.
    fft_wb_regs #(
        .POINTS_LOG2 (POINTS_LOG2)
    ) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .core     (core_bus)
    );

    // pipelined transform.
    fft_core #(
        .POINTS_LOG2 (POINTS_LOG2)
    ) u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (core_bus)
    );

endmodule
